// File: design/xbar_pkg.sv
/* Crossbar shared definitions */

package xbar_pkg;

	// Transfer widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Request opcode, same encoding as the we wire
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} xbar_op_e;

	// Arbiter states
	// ARB_BUSY is the first cycle of a grant
	// ARB_WAIT_ACK means the slave is stalling it
	typedef enum logic [1:0]
	{
		ARB_IDLE     = 2'd0,
		ARB_BUSY     = 2'd1,
		ARB_WAIT_ACK = 2'd2
	} arb_state_e;

endpackage

// File: design/xbar_master_port.sv
/* Crossbar master port */

`timescale 1ns/1ps

module xbar_master_port
#(
	parameter int NUM_SLAVES = 2,
	parameter int MID = 0,
	parameter int MID_W = 1
)
(
	input  logic memread_grant,
	input  logic arst_n_i,

	input  logic req_i,
	input  logic [xbar_pkg::ADDR_W-1:0] addr_i,
	input  logic we_i,
	input  logic [xbar_pkg::DATA_W-1:0] wdata_i,
	output logic ack_o,
	output logic [xbar_pkg::DATA_W-1:0] rdata_o,
	output logic resp_o,

	input  logic [NUM_SLAVES-1:0] gnt_i,
	input  logic [NUM_SLAVES-1:0] done_i,
	input  logic rsp_vld_i,
	input  logic [MID_W-1:0] rsp_mid_i,
	input  logic [xbar_pkg::DATA_W-1:0] rsp_rdata_i,

	output logic pend_o,
	output logic [((NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1)-1:0] tgt_o,
	output xbar_pkg::xbar_op_e op_o,
	output logic [xbar_pkg::ADDR_W-1:0] addr_o,
	output logic [xbar_pkg::DATA_W-1:0] wdata_o
);

localparam int SLV_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

logic full_q, full_d;
logic rd_pend_q, rd_pend_d;
logic ack_q, resp_q;
logic accept, free, own_rsp;
logic [SLV_W-1:0] tgt_q;
xbar_pkg::xbar_op_e op_q;
logic [xbar_pkg::ADDR_W-1:0] addr_q;
logic [xbar_pkg::DATA_W-1:0] wdata_q, rdata_q;

assign accept = req_i & ack_q;
// Our slave took the request
assign free = full_q & gnt_i[tgt_q] & done_i[tgt_q];
assign own_rsp = rsp_vld_i & (rsp_mid_i == MID_W'(MID));

always_comb
begin
	full_d = full_q;
	if (accept)
		full_d = 1'b1;
	else if (free)
		full_d = 1'b0;
	rd_pend_d = rd_pend_q;
	if (free && (op_q == xbar_pkg::OP_READ))
		rd_pend_d = 1'b1;
	// A zero-delay slave may answer in the same cycle
	if (own_rsp)
		rd_pend_d = 1'b0;
end

always_ff @(posedge memread_grant or negedge arst_n_i)
begin
	if (!arst_n_i)
	begin
		full_q <= 1'b0;
		rd_pend_q <= 1'b0;
		ack_q <= 1'b0;
		resp_q <= 1'b0;
	end
	else
	begin
		full_q <= full_d;
		rd_pend_q <= rd_pend_d;
		ack_q <= ~full_d & ~rd_pend_d;
		resp_q <= own_rsp;
	end
end

always_ff @(posedge memread_grant)
begin
	if (accept)
	begin
		// Top address bits select the slave
		tgt_q <= addr_i[xbar_pkg::ADDR_W-1 -: SLV_W];
		op_q <= xbar_pkg::xbar_op_e'(we_i);
		addr_q <= addr_i;
		wdata_q <= wdata_i;
	end
	if (own_rsp)
		rdata_q <= rsp_rdata_i;
end

assign ack_o = ack_q;
assign resp_o = resp_q;
assign rdata_o = rdata_q;
assign pend_o = full_q;
assign tgt_o = tgt_q;
assign op_o = op_q;
assign addr_o = addr_q;
assign wdata_o = wdata_q;

endmodule

// File: design/xbar_arbiter.sv
/* Round-robin slave arbiter */

`timescale 1ns/1ps

module xbar_arbiter
#(
	parameter int NUM_MASTERS = 2
)
(
	input  logic memread_grant,
	input  logic arst_n_i,

	input  logic [NUM_MASTERS-1:0] req_i,
	input  logic done_i,

	output logic [NUM_MASTERS-1:0] gnt_o,
	output logic gnt_valid_o
);

localparam int MST_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

xbar_pkg::arb_state_e state_q;
logic [NUM_MASTERS-1:0] gnt_q;
logic [NUM_MASTERS-1:0] req_avail;
logic [NUM_MASTERS-1:0] pick;
logic [MST_W-1:0] last_idx;
logic [MST_W-1:0] pick_idx;

// The master just served still shows pend in its done cycle
assign req_avail = (state_q == xbar_pkg::ARB_IDLE) ? req_i : (req_i & ~gnt_q);

// Search starts right after the last granted master
always_comb
begin
	int cand;
	pick = '0;
	pick_idx = last_idx;
	for (int k = NUM_MASTERS; k >= 1; k--)
	begin
		cand = (int'(last_idx) + k) % NUM_MASTERS;
		if (req_avail[cand])
		begin
			pick = '0;
			pick[cand] = 1'b1;
			pick_idx = cand[MST_W-1:0];
		end
	end
end

always_ff @(posedge memread_grant or negedge arst_n_i)
begin
	if (!arst_n_i)
	begin
		state_q <= xbar_pkg::ARB_IDLE;
		gnt_q <= '0;
		// Master 0 wins first
		last_idx <= MST_W'(NUM_MASTERS - 1);
	end
	else
	begin
		case (state_q)
			xbar_pkg::ARB_IDLE:
			begin
				if (|req_avail)
				begin
					gnt_q <= pick;
					last_idx <= pick_idx;
					state_q <= xbar_pkg::ARB_BUSY;
				end
			end
			xbar_pkg::ARB_BUSY, xbar_pkg::ARB_WAIT_ACK:
			begin
				if (done_i)
				begin
					// Priority rotates only once the slave took the request
					if (|req_avail)
					begin
						gnt_q <= pick;
						last_idx <= pick_idx;
						state_q <= xbar_pkg::ARB_BUSY;
					end
					else
					begin
						gnt_q <= '0;
						state_q <= xbar_pkg::ARB_IDLE;
					end
				end
				else
					state_q <= xbar_pkg::ARB_WAIT_ACK;
			end
			default:
			begin
				gnt_q <= '0;
				state_q <= xbar_pkg::ARB_IDLE;
			end
		endcase
	end
end

assign gnt_o = gnt_q;
assign gnt_valid_o = (state_q != xbar_pkg::ARB_IDLE);

endmodule

// File: design/xbar_slave_port.sv
/* Crossbar slave port */

`timescale 1ns/1ps

module xbar_slave_port
#(
	parameter int NUM_MASTERS = 2,
	parameter int RESP_DEPTH = 4
)
(
	input  logic memread_grant,
	input  logic arst_n_i,

	input  logic [NUM_MASTERS-1:0] gnt_i,
	input  logic gnt_valid_i,
	input  logic [NUM_MASTERS-1:0] mst_op_i,
	input  logic [NUM_MASTERS*xbar_pkg::ADDR_W-1:0] mst_addr_i,
	input  logic [NUM_MASTERS*xbar_pkg::DATA_W-1:0] mst_wdata_i,

	output logic s_req_o,
	output logic [xbar_pkg::ADDR_W-1:0] s_addr_o,
	output logic s_we_o,
	output logic [xbar_pkg::DATA_W-1:0] s_wdata_o,
	input  logic s_ack_i,
	input  logic [xbar_pkg::DATA_W-1:0] s_rdata_i,
	input  logic s_resp_i,

	output logic done_o,
	output logic rsp_vld_o,
	output logic [((NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1)-1:0] rsp_mid_o,
	output logic [xbar_pkg::DATA_W-1:0] rsp_rdata_o
);

localparam int MID_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
localparam int CNT_W = $clog2(RESP_DEPTH + 1);

xbar_pkg::xbar_op_e sel_op;
logic [xbar_pkg::ADDR_W-1:0] sel_addr;
logic [xbar_pkg::DATA_W-1:0] sel_wdata;
logic [MID_W-1:0] sel_mid, head_mid;

// Master IDs of reads in flight, oldest at rd_ptr
logic [MID_W-1:0] mid_fifo [RESP_DEPTH];
logic [PTR_W-1:0] wr_ptr, rd_ptr;
logic [CNT_W-1:0] cnt;
logic fifo_full, fifo_empty;
logic accept, push, bypass, do_push, do_pop;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	if (p == PTR_W'(RESP_DEPTH - 1))
		return '0;
	return p + 1'b1;
endfunction

// One-hot grant mux
always_comb
begin
	sel_op = xbar_pkg::OP_READ;
	sel_addr = '0;
	sel_wdata = '0;
	sel_mid = '0;
	for (int m = 0; m < NUM_MASTERS; m++)
	begin
		if (gnt_i[m])
		begin
			sel_op = xbar_pkg::xbar_op_e'(mst_op_i[m]);
			sel_addr = mst_addr_i[m*xbar_pkg::ADDR_W +: xbar_pkg::ADDR_W];
			sel_wdata = mst_wdata_i[m*xbar_pkg::DATA_W +: xbar_pkg::DATA_W];
			sel_mid = MID_W'(m);
		end
	end
end

assign fifo_full = (cnt == CNT_W'(RESP_DEPTH));
assign fifo_empty = (cnt == '0);

// Reads wait while every response slot is taken
assign s_req_o = gnt_valid_i & ~((sel_op == xbar_pkg::OP_READ) & fifo_full);
assign s_addr_o = sel_addr;
assign s_we_o = (sel_op == xbar_pkg::OP_WRITE);
assign s_wdata_o = sel_wdata;

assign accept = s_req_o & s_ack_i;
assign push = accept & (sel_op == xbar_pkg::OP_READ);
// Slave answered a read in the cycle it took it
assign bypass = push & s_resp_i & fifo_empty;
assign do_push = push & ~bypass;
assign do_pop = s_resp_i & ~fifo_empty;

assign head_mid = fifo_empty ? sel_mid : mid_fifo[rd_ptr];

always_ff @(posedge memread_grant or negedge arst_n_i)
begin
	if (!arst_n_i)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		cnt <= '0;
	end
	else
	begin
		if (do_push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (do_pop)
			rd_ptr <= ptr_inc(rd_ptr);
		if (do_push && !do_pop)
			cnt <= cnt + 1'b1;
		else if (do_pop && !do_push)
			cnt <= cnt - 1'b1;
	end
end

always_ff @(posedge memread_grant)
begin
	if (do_push)
		mid_fifo[wr_ptr] <= sel_mid;
end

assign done_o = accept;
assign rsp_vld_o = s_resp_i;
assign rsp_mid_o = head_mid;
assign rsp_rdata_o = s_rdata_i;

endmodule

// File: design/xbar_top.sv
/* Buffered memory crossbar */

`timescale 1ns/1ps

module xbar_top
#(
	parameter int NUM_MASTERS = 2,
	parameter int NUM_SLAVES = 2,
	parameter int RESP_DEPTH = 4
)
(
	input  logic memread_grant,
	input  logic arst_n_i,

	// Master side, one slice per master
	input  logic [NUM_MASTERS-1:0] m_req_i,
	input  logic [NUM_MASTERS*xbar_pkg::ADDR_W-1:0] m_addr_i,
	input  logic [NUM_MASTERS-1:0] m_we_i,
	input  logic [NUM_MASTERS*xbar_pkg::DATA_W-1:0] m_wdata_i,
	output logic [NUM_MASTERS-1:0] m_ack_o,
	output logic [NUM_MASTERS*xbar_pkg::DATA_W-1:0] m_rdata_o,
	output logic [NUM_MASTERS-1:0] m_resp_o,

	// Slave side, one slice per slave
	output logic [NUM_SLAVES-1:0] s_req_o,
	output logic [NUM_SLAVES*xbar_pkg::ADDR_W-1:0] s_addr_o,
	output logic [NUM_SLAVES-1:0] s_we_o,
	output logic [NUM_SLAVES*xbar_pkg::DATA_W-1:0] s_wdata_o,
	input  logic [NUM_SLAVES-1:0] s_ack_i,
	input  logic [NUM_SLAVES*xbar_pkg::DATA_W-1:0] s_rdata_i,
	input  logic [NUM_SLAVES-1:0] s_resp_i
);

localparam int ADDR_W = xbar_pkg::ADDR_W;
localparam int DATA_W = xbar_pkg::DATA_W;
localparam int SLV_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
localparam int MID_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

// Held requests from the master ports
logic mp_pend [NUM_MASTERS];
logic [SLV_W-1:0] mp_tgt [NUM_MASTERS];
logic [NUM_MASTERS-1:0] mp_op;
logic [NUM_MASTERS*ADDR_W-1:0] mp_addr;
logic [NUM_MASTERS*DATA_W-1:0] mp_wdata;
logic [NUM_SLAVES-1:0] mp_gnt [NUM_MASTERS];

// Arbitration per slave
logic [NUM_MASTERS-1:0] arb_req [NUM_SLAVES];
logic [NUM_MASTERS-1:0] arb_gnt [NUM_SLAVES];
logic arb_gnt_valid [NUM_SLAVES];

// Slave port completion and response buses
logic [NUM_SLAVES-1:0] sp_done;
logic sp_rsp_vld [NUM_SLAVES];
logic [MID_W-1:0] sp_rsp_mid [NUM_SLAVES];
logic [DATA_W-1:0] sp_rsp_rdata [NUM_SLAVES];

// Responses merged toward each master
logic mr_vld [NUM_MASTERS];
logic [MID_W-1:0] mr_mid [NUM_MASTERS];
logic [DATA_W-1:0] mr_rdata [NUM_MASTERS];

genvar m, s;

generate
	for (s = 0; s < NUM_SLAVES; s++)
	begin : g_cross
		for (m = 0; m < NUM_MASTERS; m++)
		begin : g_mst
			assign arb_req[s][m] = mp_pend[m] & (mp_tgt[m] == SLV_W'(s));
			assign mp_gnt[m][s] = arb_gnt[s][m];
		end
	end

	for (m = 0; m < NUM_MASTERS; m++)
	begin : g_master
		// At most one read per master is in flight, so one slave matches
		always_comb
		begin
			mr_vld[m] = 1'b0;
			mr_mid[m] = '0;
			mr_rdata[m] = '0;
			for (int k = 0; k < NUM_SLAVES; k++)
			begin
				if (sp_rsp_vld[k] && (sp_rsp_mid[k] == MID_W'(m)))
				begin
					mr_vld[m] = 1'b1;
					mr_mid[m] = mr_mid[m] | sp_rsp_mid[k];
					mr_rdata[m] = mr_rdata[m] | sp_rsp_rdata[k];
				end
			end
		end

		xbar_master_port
		#(
			.NUM_SLAVES(NUM_SLAVES),
			.MID(m),
			.MID_W(MID_W)
		) i_master_port (
			.memread_grant(memread_grant),
			.arst_n_i(arst_n_i),
			.req_i(m_req_i[m]),
			.addr_i(m_addr_i[m*ADDR_W +: ADDR_W]),
			.we_i(m_we_i[m]),
			.wdata_i(m_wdata_i[m*DATA_W +: DATA_W]),
			.ack_o(m_ack_o[m]),
			.rdata_o(m_rdata_o[m*DATA_W +: DATA_W]),
			.resp_o(m_resp_o[m]),
			.gnt_i(mp_gnt[m]),
			.done_i(sp_done),
			.rsp_vld_i(mr_vld[m]),
			.rsp_mid_i(mr_mid[m]),
			.rsp_rdata_i(mr_rdata[m]),
			.pend_o(mp_pend[m]),
			.tgt_o(mp_tgt[m]),
			.op_o(mp_op[m]),
			.addr_o(mp_addr[m*ADDR_W +: ADDR_W]),
			.wdata_o(mp_wdata[m*DATA_W +: DATA_W])
		);
	end

	for (s = 0; s < NUM_SLAVES; s++)
	begin : g_slave
		xbar_arbiter
		#(
			.NUM_MASTERS(NUM_MASTERS)
		) i_arbiter (
			.memread_grant(memread_grant),
			.arst_n_i(arst_n_i),
			.req_i(arb_req[s]),
			.done_i(sp_done[s]),
			.gnt_o(arb_gnt[s]),
			.gnt_valid_o(arb_gnt_valid[s])
		);

		xbar_slave_port
		#(
			.NUM_MASTERS(NUM_MASTERS),
			.RESP_DEPTH(RESP_DEPTH)
		) i_slave_port (
			.memread_grant(memread_grant),
			.arst_n_i(arst_n_i),
			.gnt_i(arb_gnt[s]),
			.gnt_valid_i(arb_gnt_valid[s]),
			.mst_op_i(mp_op),
			.mst_addr_i(mp_addr),
			.mst_wdata_i(mp_wdata),
			.s_req_o(s_req_o[s]),
			.s_addr_o(s_addr_o[s*ADDR_W +: ADDR_W]),
			.s_we_o(s_we_o[s]),
			.s_wdata_o(s_wdata_o[s*DATA_W +: DATA_W]),
			.s_ack_i(s_ack_i[s]),
			.s_rdata_i(s_rdata_i[s*DATA_W +: DATA_W]),
			.s_resp_i(s_resp_i[s]),
			.done_o(sp_done[s]),
			.rsp_vld_o(sp_rsp_vld[s]),
			.rsp_mid_o(sp_rsp_mid[s]),
			.rsp_rdata_o(sp_rsp_rdata[s])
		);
	end
endgenerate

endmodule

// File: bench/xbar_tb_mem.sv
/* Testbench slave memory */

`timescale 1ns/1ps

module xbar_tb_mem
#(
	parameter int SEED = 1
)
(
	input  logic memread_grant,
	input  logic arst_n_i,
	input  logic hold_i,
	input  logic req_i,
	input  logic [31:0] addr_i,
	input  logic we_i,
	input  logic [31:0] wdata_i,
	output logic ack_o,
	output logic [31:0] rdata_o,
	output logic resp_o
);

integer seed = SEED;
logic [31:0] mem [logic [31:0]];
logic [31:0] rd_data [$];
int rd_wait [$];
int wait_cnt;
logic [31:0] lat_addr, lat_wdata;
logic lat_we;

// Contents of a word never written
function automatic logic [31:0] fill_word(input logic [31:0] a);
	return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
endfunction

// Outputs change on the falling edge, the DUT samples on the rising one
always @(negedge memread_grant or negedge arst_n_i)
begin
	if (!arst_n_i)
	begin
		ack_o = 1'b0;
		resp_o = 1'b0;
		rdata_o = '0;
		wait_cnt = 0;
		rd_data.delete();
		rd_wait.delete();
	end
	else
	begin
		resp_o = 1'b0;
		if (ack_o)
		begin
			// Transfer took place on the last rising edge
			ack_o = 1'b0;
			if (lat_we)
				mem[lat_addr] = lat_wdata;
			else
			begin
				rd_data.push_back(mem.exists(lat_addr) ? mem[lat_addr] : fill_word(lat_addr));
				rd_wait.push_back($unsigned($random(seed)) % 4);
			end
		end
		else if (req_i && !hold_i)
		begin
			if (wait_cnt == 0)
			begin
				ack_o = 1'b1;
				lat_addr = addr_i;
				lat_we = we_i;
				lat_wdata = wdata_i;
				wait_cnt = $unsigned($random(seed)) % 4;
			end
			else
				wait_cnt--;
		end
		// Responses leave in acceptance order
		if (rd_data.size() > 0)
		begin
			if (rd_wait[0] == 0)
			begin
				resp_o = 1'b1;
				rdata_o = rd_data.pop_front();
				void'(rd_wait.pop_front());
			end
			else
				rd_wait[0]--;
		end
	end
end

endmodule

// File: bench/xbar_tb.sv
/* Crossbar testbench */

`timescale 1ns/1ps

module xbar_tb;

localparam int NUM_TXN = 200;
localparam int TIMEOUT = NUM_TXN * 2 * 20;

logic memread_grant = 1'b0;
logic arst_n_i;
logic [1:0] m_req_i, m_we_i, m_ack_o, m_resp_o;
logic [63:0] m_addr_i, m_wdata_i, m_rdata_o;
logic [1:0] s_req_o, s_we_o, s_ack_i, s_resp_i;
logic [63:0] s_addr_o, s_wdata_o, s_rdata_i;
logic [1:0] hold;
logic steer;

integer seed = 44092;
int cycles = 0;
int errors = 0;
int checks = 0;
int issued = 0;
int accepted [2];
logic [31:0] shadow [logic [31:0]];
logic [31:0] exp_q [2][$];
logic busy [2];
int cur_slave [2];
int issue_cyc [2];
int prev_acc [2];

always #50 memread_grant = ~memread_grant;

xbar_top #(.NUM_MASTERS(2), .NUM_SLAVES(2), .RESP_DEPTH(4)) i_xbar_top (
	.memread_grant(memread_grant), .arst_n_i(arst_n_i),
	.m_req_i(m_req_i), .m_addr_i(m_addr_i), .m_we_i(m_we_i), .m_wdata_i(m_wdata_i),
	.m_ack_o(m_ack_o), .m_rdata_o(m_rdata_o), .m_resp_o(m_resp_o),
	.s_req_o(s_req_o), .s_addr_o(s_addr_o), .s_we_o(s_we_o), .s_wdata_o(s_wdata_o),
	.s_ack_i(s_ack_i), .s_rdata_i(s_rdata_i), .s_resp_i(s_resp_i)
);

genvar g;
generate
	for (g = 0; g < 2; g++)
	begin : g_mem
		xbar_tb_mem #(.SEED(44092 + g + 1)) i_mem (
			.memread_grant(memread_grant), .arst_n_i(arst_n_i), .hold_i(hold[g]),
			.req_i(s_req_o[g]), .addr_i(s_addr_o[g*32 +: 32]), .we_i(s_we_o[g]),
			.wdata_i(s_wdata_o[g*32 +: 32]), .ack_o(s_ack_i[g]),
			.rdata_o(s_rdata_i[g*32 +: 32]), .resp_o(s_resp_i[g])
		);
	end
endgenerate

// Same fill rule as the slave memories
function automatic logic [31:0] fill_word(input logic [31:0] a);
	return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
endfunction

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	if (exp !== act)
	begin
		errors++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic run_master(input int m);
	logic [31:0] addr, data;
	logic we;
	int s;
	for (int n = 0; n < NUM_TXN; n++)
	begin
		@(negedge memread_grant);
		m_req_i[m] = 1'b0;
		// Next request only once the slave has taken the previous one
		while (busy[m])
			@(negedge memread_grant);
		s = (m == 1 && steer) ? 1 : $unsigned($random(seed)) % 2;
		// Master m owns bit 8 of the address in each slave
		addr = (32'(s) << 31) | (32'(m) << 8) | ((32'($random(seed)) & 32'hf) << 2);
		we = $random(seed);
		data = $random(seed);
		busy[m] = 1'b1;
		cur_slave[m] = s;
		issue_cyc[m] = 32'h7fff_ffff;
		m_req_i[m] = 1'b1;
		m_addr_i[m*32 +: 32] = addr;
		m_we_i[m] = we;
		m_wdata_i[m*32 +: 32] = data;
		do
			@(posedge memread_grant);
		while (!m_ack_o[m]);
		issue_cyc[m] = cycles;
		issued++;
		if (we)
			shadow[addr] = data;
		else
			exp_q[m].push_back(shadow.exists(addr) ? shadow[addr] : fill_word(addr));
	end
	@(negedge memread_grant);
	m_req_i[m] = 1'b0;
endtask

// Slave 0 stalls while slave 1 must keep moving
task automatic stall_slave0;
	int start;
	repeat (200) @(negedge memread_grant);
	steer = 1'b1;
	do
		@(negedge memread_grant);
	while (busy[1] && cur_slave[1] == 0);
	hold[0] = 1'b1;
	start = accepted[1];
	repeat (100) @(negedge memread_grant);
	hold[0] = 1'b0;
	steer = 1'b0;
	if (accepted[1] == start)
	begin
		errors++;
		$display("Slave 1 accepted no transfer while slave 0 was stalled");
	end
endtask

always @(negedge memread_grant)
begin
	cycles++;
	if (cycles >= TIMEOUT)
	begin
		$display("Timeout after %0d cycles with transfers still open", cycles);
		$display("Test failed");
		$finish;
	end
end

// Slave side and response monitors
always @(posedge memread_grant)
begin
	logic [31:0] a;
	int mst;
	if (arst_n_i)
	begin
		for (int s = 0; s < 2; s++)
		begin
			if (s_req_o[s] && s_ack_i[s])
			begin
				a = s_addr_o[s*32 +: 32];
				mst = a[8];
				check_val("s_addr_o slave bit", 32'(s), 32'(a[31]));
				if (s_we_o[s])
					check_val("s_wdata_o", shadow[a], s_wdata_o[s*32 +: 32]);
				if (busy[1-mst] && cur_slave[1-mst] == s && issue_cyc[1-mst] < prev_acc[s])
					check_val("arbiter grant order", 32'(1 - mst), 32'(mst));
				prev_acc[s] = cycles;
				busy[mst] = 1'b0;
				accepted[s]++;
			end
		end
		for (int m = 0; m < 2; m++)
		begin
			if (m_resp_o[m])
			begin
				if (exp_q[m].size() == 0)
				begin
					errors++;
					$display("Master %0d got a response it did not ask for", m);
				end
				else
					check_val("m_rdata_o", exp_q[m].pop_front(), m_rdata_o[m*32 +: 32]);
			end
		end
	end
end

initial
begin
	arst_n_i = 1'b0;
	m_req_i = '0;
	m_we_i = '0;
	m_addr_i = '0;
	m_wdata_i = '0;
	hold = '0;
	steer = 1'b0;
	for (int i = 0; i < 2; i++)
	begin
		busy[i] = 1'b0;
		accepted[i] = 0;
		prev_acc[i] = -1;
		issue_cyc[i] = 0;
		cur_slave[i] = 0;
	end
	repeat (3)
	begin
		@(negedge memread_grant);
		check_val("m_ack_o", 0, 32'(m_ack_o));
		check_val("m_resp_o", 0, 32'(m_resp_o));
		check_val("s_req_o", 0, 32'(s_req_o));
	end
	arst_n_i = 1'b1;
	@(posedge memread_grant);
	check_val("m_ack_o", 0, 32'(m_ack_o));
	check_val("m_resp_o", 0, 32'(m_resp_o));
	check_val("s_req_o", 0, 32'(s_req_o));
	fork
		run_master(0);
		run_master(1);
		stall_slave0();
	join
	// Drain outstanding transfers and reads
	while (busy[0] || busy[1] || exp_q[0].size() > 0 || exp_q[1].size() > 0)
		@(negedge memread_grant);
	repeat (4) @(negedge memread_grant);
	check_val("accepted transfers", 32'(issued), 32'(accepted[0] + accepted[1]));
	$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
	if (errors == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule

// File: project.f
design/xbar_pkg.sv
design/xbar_master_port.sv
design/xbar_arbiter.sv
design/xbar_slave_port.sv
design/xbar_top.sv
bench/xbar_tb_mem.sv
bench/xbar_tb.sv

// File: Makefile
# Verilator build for the memory crossbar

VERILATOR   ?= verilator
VFLAGS      ?= --timing -Wno-fatal
TOP         ?= xbar_tb
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
PASS_MSG    ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
